/* ps2_pkg.sv */
package ps2_pkg;

    // ----------------------------------------
    // frame layout on the PS/2 wire
    // ----------------------------------------

    // members are declared MSB first, so bit 0 holds the start bit,
    // the first bit on the wire, and data keeps its natural bit order
    typedef struct packed {
        logic       stop;
        logic       parity;
        logic [7:0] data;
        logic       start;
    } ps2_frame_t;

    localparam int FRAME_BITS = 11;

    // keyboard prefix sent before the code of a released key
    localparam logic [7:0] BREAK_CODE = 8'hF0;

    // ----------------------------------------
    // receive FIFO sizing
    // ----------------------------------------

    // depth must be a power of two
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    // one extra bit tells a full FIFO from an empty one
    typedef logic [FIFO_AW:0] fifo_ptr_t;

    // ----------------------------------------
    // key tracker FSM
    // ----------------------------------------

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        MAKE,
        BREAK
    } key_state_t;

endpackage

/* disp_pkg.sv */
package disp_pkg;

    // seven-segment pattern, active low
    // segments a to g sit in bits 0 to 6, bit 7 is the decimal point
    typedef logic [7:0] seg_t;

    // every segment and the decimal point dark
    localparam seg_t SEG_BLANK = 8'hFF;

    // the two hex digits of the key value and a shared blank flag
    typedef struct packed {
        logic [3:0] hi;
        logic [3:0] lo;
        logic       blank;
    } hex_pair_t;

endpackage

/* ps2_receiver.sv */
`timescale 1ns/1ns

module ps2_receiver
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    input  logic       nextdata_n,
    output logic [7:0] data,
    output logic       ready
);

    logic                  clk_s1;
    logic                  clk_s2;
    logic                  clk_s3;
    logic                  dat_s1;
    logic                  dat_s2;
    logic                  fall;
    logic [3:0]            bit_cnt;
    logic                  frame_done;
    logic                  frame_ok;
    ps2_pkg::ps2_frame_t   frame;
    logic [7:0]            mem [ps2_pkg::FIFO_DEPTH];
    ps2_pkg::fifo_ptr_t    wr_ptr;
    ps2_pkg::fifo_ptr_t    rd_ptr;
    logic                  empty;
    logic                  full;
    logic                  push;
    logic                  pop;

    // ----------------------------------------
    // line synchronizers
    // ----------------------------------------

    // both lines idle high, so the flops start high and no false edge follows reset
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_s1 <= 1'b1;
            clk_s2 <= 1'b1;
            clk_s3 <= 1'b1;
            dat_s1 <= 1'b1;
            dat_s2 <= 1'b1;
        end
        else
        begin
            clk_s1 <= ps2_clk;
            clk_s2 <= clk_s1;
            clk_s3 <= clk_s2;
            dat_s1 <= ps2_dat;
            dat_s2 <= dat_s1;
        end
    end

    assign fall = clk_s3 & ~clk_s2;

    // ----------------------------------------
    // frame deserializer
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            if (fall)
            begin
                if (bit_cnt == 4'(ps2_pkg::FRAME_BITS - 1))
                begin
                    bit_cnt    <= '0;
                    frame_done <= 1'b1;
                end
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // bits arrive LSB first and shift in from the top
    always_ff @(posedge clk)
    begin
        if (fall)
            frame <= {dat_s2, frame[ps2_pkg::FRAME_BITS-1:1]};
    end

    // start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~frame.start & frame.stop & (^{frame.data, frame.parity});

    // a bad frame or a full FIFO drops the byte
    assign push = frame_done & frame_ok & ~full;
    assign pop  = ~nextdata_n & ~empty;

    // ----------------------------------------
    // receive FIFO
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr[ps2_pkg::FIFO_AW-1:0]] <= frame.data;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + ps2_pkg::fifo_ptr_t'(1);
            if (pop)
                rd_ptr <= rd_ptr + ps2_pkg::fifo_ptr_t'(1);
        end
    end

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ps2_pkg::FIFO_AW] != rd_ptr[ps2_pkg::FIFO_AW])
                && (wr_ptr[ps2_pkg::FIFO_AW-1:0] == rd_ptr[ps2_pkg::FIFO_AW-1:0]);

    assign ready = ~empty;
    assign data  = mem[rd_ptr[ps2_pkg::FIFO_AW-1:0]];

    // the tracker may only pop while a byte is waiting
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst)
        !nextdata_n |-> ready);

    // fill level stays within the depth, so reads never overtake writes
    a_ptr_order: assert property (@(posedge clk) disable iff (!rst)
        ps2_pkg::fifo_ptr_t'(wr_ptr - rd_ptr) <= ps2_pkg::FIFO_DEPTH);

endmodule

/* key_tracker.sv */
`timescale 1ns/1ns

module key_tracker
(
    input  logic                clk,
    input  logic                rst,
    input  logic                ready,
    input  logic [7:0]          data,
    output logic                nextdata_n,
    output disp_pkg::hex_pair_t digits
);

    ps2_pkg::key_state_t state;
    logic [7:0]          byte_q;
    logic [7:0]          key_value;
    logic                break_pending;

    // ----------------------------------------
    // fetch FSM
    // ----------------------------------------

    // nextdata_n drops on entry to FETCH and pops the head at the end of it
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state      <= ps2_pkg::IDLE;
            nextdata_n <= 1'b1;
        end
        else
        begin
            nextdata_n <= 1'b1;
            case (state)
                ps2_pkg::IDLE:
                begin
                    if (ready)
                    begin
                        state      <= ps2_pkg::FETCH;
                        nextdata_n <= 1'b0;
                    end
                end
                ps2_pkg::FETCH:
                begin
                    if (data == ps2_pkg::BREAK_CODE)
                        state <= ps2_pkg::BREAK;
                    else
                        state <= ps2_pkg::MAKE;
                end
                default:
                begin
                    state <= ps2_pkg::IDLE;
                end
            endcase
        end
    end

    // head of the FIFO is still valid during FETCH
    always_ff @(posedge clk)
    begin
        if (state == ps2_pkg::FETCH)
            byte_q <= data;
    end

    // ----------------------------------------
    // key value
    // ----------------------------------------

    // the code after a break prefix names the released key and clears the value
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            key_value     <= 8'h00;
            break_pending <= 1'b0;
        end
        else if (state == ps2_pkg::BREAK)
        begin
            break_pending <= 1'b1;
        end
        else if (state == ps2_pkg::MAKE)
        begin
            key_value     <= break_pending ? 8'h00 : byte_q;
            break_pending <= 1'b0;
        end
    end

    always_comb
    begin
        digits.hi    = key_value[7:4];
        digits.lo    = key_value[3:0];
        digits.blank = (key_value == 8'h00);
    end

    a_pop_in_fetch: assert property (@(posedge clk) disable iff (!rst)
        !nextdata_n |-> state == ps2_pkg::FETCH);

    // all four encodings are states, so only an unknown value is illegal
    a_state_legal: assert property (@(posedge clk) disable iff (!rst)
        !$isunknown(state));

endmodule

/* seg7_decoder.sv */
`timescale 1ns/1ns

module seg7_decoder
(
    input  logic           [3:0] num,
    input  logic                 blank,
    output disp_pkg::seg_t       seg_out
);

    disp_pkg::seg_t pattern;

    // common-anode patterns, a in bit 0 through g in bit 6, dp kept dark
    always_comb
    begin
        case (num)
            4'h0: pattern = 8'hC0;
            4'h1: pattern = 8'hF9;
            4'h2: pattern = 8'hA4;
            4'h3: pattern = 8'hB0;
            4'h4: pattern = 8'h99;
            4'h5: pattern = 8'h92;
            4'h6: pattern = 8'h82;
            4'h7: pattern = 8'hF8;
            4'h8: pattern = 8'h80;
            4'h9: pattern = 8'h90;
            4'hA: pattern = 8'h88;
            4'hB: pattern = 8'h83;
            4'hC: pattern = 8'hC6;
            4'hD: pattern = 8'hA1;
            4'hE: pattern = 8'h86;
            default: pattern = 8'h8E;
        endcase
    end

    assign seg_out = blank ? disp_pkg::SEG_BLANK : pattern;

endmodule

/* kbd_display_top.sv */
`timescale 1ns/1ns

module kbd_display_top
(
    input  logic           clk,
    input  logic           rst,
    input  logic           ps2_clk,
    input  logic           ps2_dat,
    output disp_pkg::seg_t seg1,
    output disp_pkg::seg_t seg2
);

    logic [7:0]          rx_data;
    logic                rx_ready;
    logic                nextdata_n;
    disp_pkg::hex_pair_t digits;

    ps2_receiver rx_i
    (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .nextdata_n (nextdata_n),
        .data       (rx_data),
        .ready      (rx_ready)
    );

    key_tracker trk_i
    (
        .clk        (clk),
        .rst        (rst),
        .ready      (rx_ready),
        .data       (rx_data),
        .nextdata_n (nextdata_n),
        .digits     (digits)
    );

    // seg1 shows the low digit, seg2 the high digit
    seg7_decoder seg_lo_i
    (
        .num     (digits.lo),
        .blank   (digits.blank),
        .seg_out (seg1)
    );

    seg7_decoder seg_hi_i
    (
        .num     (digits.hi),
        .blank   (digits.blank),
        .seg_out (seg2)
    );

endmodule

/* tb_kbd_display.sv */
`timescale 1ns/1ns

module tb_kbd_display;

    // half of the 20 us PS/2 clock period, in clk cycles
    localparam int PS2_HALF   = 1000;
    localparam int WAIT_LIMIT = 2000;
    localparam int SETTLE     = 20;

    logic           clk;
    logic           rst;
    logic           ps2_clk;
    logic           ps2_dat;
    disp_pkg::seg_t seg1;
    disp_pkg::seg_t seg2;

    integer seed;
    int     error_count;
    int     test_count;
    int     test_fails;

    kbd_display_top dut_i
    (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .seg1    (seg1),
        .seg2    (seg2)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    // ends 1 ns after a rising edge, where inputs change and outputs are settled
    task automatic advance_cycles(input int n);
        repeat (n)
            @(posedge clk);
        #1;
    endtask

    // ----------------------------------------
    // expected display values
    // ----------------------------------------

    // lit segments, active high, g down to a
    function automatic disp_pkg::seg_t digit_pattern(input logic [3:0] digit);
        logic [6:0] lit;
        case (digit)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return {1'b1, ~lit};
    endfunction

    // a key value of zero blanks both digits
    function automatic disp_pkg::seg_t shown_digit(input logic [7:0] code, input logic hi);
        if (code == 8'h00)
            return disp_pkg::SEG_BLANK;
        return digit_pattern(hi ? code[7:4] : code[3:0]);
    endfunction

    // ----------------------------------------
    // PS/2 device model
    // ----------------------------------------

    function automatic ps2_pkg::ps2_frame_t make_frame(input logic [7:0] code,
                                                       input logic bad_parity,
                                                       input logic bad_stop);
        ps2_pkg::ps2_frame_t f;
        f.start  = 1'b0;
        f.data   = code;
        f.parity = ~(^code) ^ bad_parity;
        f.stop   = ~bad_stop;
        return f;
    endfunction

    // data changes while ps2_clk is high, the receiver samples on the fall
    task automatic send_frame(input ps2_pkg::ps2_frame_t frame);
        logic [10:0] bits;
        bits = frame;
        for (int i = 0; i < 11; i++)
        begin
            ps2_dat = bits[i];
            advance_cycles(PS2_HALF / 2);
            ps2_clk = 1'b0;
            advance_cycles(PS2_HALF);
            ps2_clk = 1'b1;
            advance_cycles(PS2_HALF / 2);
        end
        ps2_dat = 1'b1;
    endtask

    task automatic send_code(input logic [7:0] code);
        send_frame(make_frame(code, 1'b0, 1'b0));
    endtask

    // ----------------------------------------
    // checks
    // ----------------------------------------

    task automatic check_seg(input string name, input disp_pkg::seg_t expected,
                             input disp_pkg::seg_t actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("** Error at %0t ns: %s expected 8'h%02h, got 8'h%02h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic expect_code(input logic [7:0] code);
        int                  cycles;
        ps2_pkg::key_state_t st;
        cycles = 0;
        while ((seg1 !== shown_digit(code, 1'b0) || seg2 !== shown_digit(code, 1'b1))
               && cycles < WAIT_LIMIT)
        begin
            advance_cycles(1);
            cycles++;
        end
        if (seg1 !== shown_digit(code, 1'b0) || seg2 !== shown_digit(code, 1'b1))
        begin
            st = dut_i.trk_i.state;
            $display("timeout: display did not show code %02h within %0d cycles, tracker in %s",
                     code, WAIT_LIMIT, st.name());
        end
        check_seg("seg1", shown_digit(code, 1'b0), seg1);
        check_seg("seg2", shown_digit(code, 1'b1), seg2);
    endtask

    // the display must keep showing code for the whole window
    task automatic hold_display(input logic [7:0] code);
        for (int i = 0; i < SETTLE; i++)
        begin
            if (seg1 !== shown_digit(code, 1'b0) || seg2 !== shown_digit(code, 1'b1))
            begin
                check_seg("seg1", shown_digit(code, 1'b0), seg1);
                check_seg("seg2", shown_digit(code, 1'b1), seg2);
                break;
            end
            advance_cycles(1);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before)
            $display("test %s: pass", name);
        else
        begin
            test_fails++;
            $display("test %s: FAIL", name);
        end
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------

    task automatic reset_state_blank();
        int errs;
        errs = error_count;
        check_seg("seg1", disp_pkg::SEG_BLANK, seg1);
        check_seg("seg2", disp_pkg::SEG_BLANK, seg2);
        end_test("reset blanks display", errs);
    endtask

    task automatic make_code_shown();
        int errs;
        errs = error_count;
        send_code(8'h1C);
        expect_code(8'h1C);
        send_code(8'hA5);
        expect_code(8'hA5);
        end_test("make code shown", errs);
    endtask

    task automatic break_clears_display();
        int errs;
        errs = error_count;
        send_code(8'h2B);
        expect_code(8'h2B);
        // the prefix alone leaves the value in place
        send_code(ps2_pkg::BREAK_CODE);
        hold_display(8'h2B);
        send_code(8'h2B);
        expect_code(8'h00);
        end_test("break clears display", errs);
    endtask

    task automatic bad_frames_ignored();
        int errs;
        errs = error_count;
        send_code(8'h3A);
        expect_code(8'h3A);
        send_frame(make_frame(8'h44, 1'b1, 1'b0));
        hold_display(8'h3A);
        send_frame(make_frame(8'h55, 1'b0, 1'b1));
        hold_display(8'h3A);
        send_code(8'h4D);
        expect_code(8'h4D);
        end_test("bad frames ignored", errs);
    endtask

    // each code must show in turn, so a dropped or reordered byte is caught
    task automatic burst_keeps_order();
        int         errs;
        logic [7:0] code;
        logic [7:0] prev;
        errs = error_count;
        prev = 8'h4D;
        for (int i = 0; i < 10; i++)
        begin
            code = 8'($random(seed));
            while (code == ps2_pkg::BREAK_CODE || code == 8'h00 || code == prev)
                code = 8'($random(seed));
            send_code(code);
            expect_code(code);
            prev = code;
        end
        expect_code(prev);
        end_test("burst keeps order", errs);
    endtask

    task automatic zero_code_blanks();
        int errs;
        errs = error_count;
        send_code(8'h3C);
        expect_code(8'h3C);
        send_code(8'h00);
        expect_code(8'h00);
        end_test("zero code blanks display", errs);
    endtask

    initial
    begin
        rst         = 1'b0;
        ps2_clk     = 1'b1;
        ps2_dat     = 1'b1;
        seed        = 32'hb918;
        error_count = 0;
        test_count  = 0;
        test_fails  = 0;
        advance_cycles(8);
        rst = 1'b1;
        advance_cycles(2);

        reset_state_blank();
        make_code_shown();
        break_clears_display();
        bad_frames_ignored();
        burst_keeps_order();
        zero_code_blanks();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 test_count, test_fails, error_count);
        if (error_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* kbd_display.f */
ps2_pkg.sv
disp_pkg.sv
ps2_receiver.sv
key_tracker.sv
seg7_decoder.sv
kbd_display_top.sv
tb_kbd_display.sv

/* Makefile */
# Verilator build and run for the PS/2 keyboard display

VERILATOR ?= verilator
TOP       ?= tb_kbd_display
RTL_TOP   ?= kbd_display_top
FILELIST  ?= kbd_display.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall

SOURCES := $(shell grep '\.sv$$' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
